/* hw/aes_cfg.svh */
// AES accelerator configuration
// Bus widths, round count and the Wishbone register map
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Wishbone port, byte addressed
`define AES_WB_AW 8
`define AES_WB_DW 32

// AES-128 block geometry
`define AES_NUM_ROUNDS 10
`define AES_WORDS 4

// Register offsets
`define AES_REG_CTRL   8'h00
`define AES_REG_STATUS 8'h04
`define AES_REG_KEY0   8'h10
`define AES_REG_KEY1   8'h14
`define AES_REG_KEY2   8'h18
`define AES_REG_KEY3   8'h1C
`define AES_REG_DIN    8'h20
`define AES_REG_DOUT   8'h24

`endif

/* hw/aes_pkg.sv */
// AES shared types
// The 128-bit block is used both as one flat vector by the round
// arithmetic and as four 32-bit words by the bus side
`default_nettype none

`include "aes_cfg.svh"

package aes_pkg;

  // Word 0 sits in bits 31:0, so the last eight hex digits
  // of a FIPS-197 string land in word 0
  typedef union packed {
    logic [`AES_WORDS*`AES_WB_DW-1:0]      flat;
    logic [`AES_WORDS-1:0][`AES_WB_DW-1:0] words;
  } aes_block_u;

endpackage

`default_nettype wire

/* hw/aes_round.sv */
// AES encryption round
// SubBytes, ShiftRows and MixColumns followed by AddRoundKey with the
// next round key, which is produced here by one key-schedule step
`timescale 1ns/1ps
`default_nettype none

module aes_round (
  input  aes_pkg::aes_block_u state_i,
  input  aes_pkg::aes_block_u rkey_i,
  input  logic [7:0]          rcon_i,
  input  logic                final_i,
  output aes_pkg::aes_block_u state_o,
  output aes_pkg::aes_block_u next_key_o
);

  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ p;
      p = xtime(p);
    end
    return acc;
  endfunction

  // Inverse is a^254, built from successive squares; zero maps to zero
  function automatic logic [7:0] sbox(input logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] inv;
    sq  = a;
    inv = 8'h01;
    for (int i = 0; i < 7; i++)
    begin
      sq  = gf_mul(sq, sq);
      inv = gf_mul(inv, sq);
    end
    // Affine transform
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  // Byte 0 is the first byte of the FIPS string
  logic [0:15][7:0] st_b;
  logic [0:15][7:0] sb_b;
  logic [0:15][7:0] sr_b;
  logic [0:15][7:0] mc_b;
  logic [31:0]      w0, w1, w2, w3;
  logic [31:0]      temp;
  logic [31:0]      nw0, nw1, nw2, nw3;

  assign st_b = state_i.flat;

  always_comb
  begin
    for (int i = 0; i < 16; i++)
    begin
      sb_b[i] = sbox(st_b[i]);
    end
    // Row r rotates left by r columns
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        sr_b[4*c+r] = sb_b[4*((c+r)%4)+r];
      end
    end
    for (int c = 0; c < 4; c++)
    begin
      mc_b[4*c]   = xtime(sr_b[4*c]) ^ gf_mul(sr_b[4*c+1], 8'h03) ^
                    sr_b[4*c+2] ^ sr_b[4*c+3];
      mc_b[4*c+1] = sr_b[4*c] ^ xtime(sr_b[4*c+1]) ^
                    gf_mul(sr_b[4*c+2], 8'h03) ^ sr_b[4*c+3];
      mc_b[4*c+2] = sr_b[4*c] ^ sr_b[4*c+1] ^ xtime(sr_b[4*c+2]) ^
                    gf_mul(sr_b[4*c+3], 8'h03);
      mc_b[4*c+3] = gf_mul(sr_b[4*c], 8'h03) ^ sr_b[4*c+1] ^
                    sr_b[4*c+2] ^ xtime(sr_b[4*c+3]);
    end
  end

  // Key schedule, w0 is the first column of the round key
  assign w0   = rkey_i.flat[127:96];
  assign w1   = rkey_i.flat[95:64];
  assign w2   = rkey_i.flat[63:32];
  assign w3   = rkey_i.flat[31:0];
  assign temp = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])} ^
                {rcon_i, 24'h000000};
  assign nw0  = w0 ^ temp;
  assign nw1  = w1 ^ nw0;
  assign nw2  = w2 ^ nw1;
  assign nw3  = w3 ^ nw2;

  assign next_key_o.flat = {nw0, nw1, nw2, nw3};

  // Last round has no MixColumns
  assign state_o.flat = (final_i ? sr_b : mc_b) ^ next_key_o.flat;

endmodule

`default_nettype wire

/* hw/aes_step_counter.sv */
// Step counter
// Up-counter with clear and enable, flags its terminal value
`timescale 1ns/1ps
`default_nettype none

module aes_step_counter #(
  parameter int WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             en_i,
  input  logic [WIDTH-1:0] last_val_i,
  output logic [WIDTH-1:0] count_o,
  output logic             last_o
);

  logic [WIDTH-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      count_q <= '0;
    else if (clr_i)
      count_q <= '0;
    else if (en_i)
      count_q <= count_q + 1'b1;
  end

  assign count_o = count_q;
  assign last_o  = (count_q == last_val_i);

endmodule

`default_nettype wire

/* hw/aes_core.sv */
// Iterative AES-128 encryption core
// Initial AddRoundKey on start, then one round per clock;
// done pulses with the final round written
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_core (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  aes_pkg::aes_block_u key_i,
  input  aes_pkg::aes_block_u block_i,
  output aes_pkg::aes_block_u result_o,
  output logic                done_o
);

  aes_pkg::aes_block_u state_q, rkey_q;
  aes_pkg::aes_block_u round_state, round_key;
  logic [7:0]          rcon_q;
  logic                running_q;
  logic                done_q;
  logic                round_last;

  aes_round u_round (
    .state_i    (state_q),
    .rkey_i     (rkey_q),
    .rcon_i     (rcon_q),
    .final_i    (round_last),
    .state_o    (round_state),
    .next_key_o (round_key)
  );

  // Rounds 1..N map to counts 0..N-1
  aes_step_counter #(.WIDTH(4)) u_round_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clr_i      (start_i),
    .en_i       (running_q),
    .last_val_i (4'(`AES_NUM_ROUNDS - 1)),
    .count_o    (),
    .last_o     (round_last)
  );

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      state_q.flat <= block_i.flat ^ key_i.flat;
      rkey_q       <= key_i;
      rcon_q       <= 8'h01;
    end
    else if (running_q)
    begin
      state_q <= round_state;
      rkey_q  <= round_key;
      rcon_q  <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= running_q & round_last;
      if (start_i)
        running_q <= 1'b1;
      else if (running_q & round_last)
        running_q <= 1'b0;
    end
  end

  assign result_o = state_q;
  assign done_o   = done_q;

endmodule

`default_nettype wire

/* hw/aes_engine.sv */
// AES engine
// Owns the 128-bit data register: filled and drained one word at a
// time at the counter position, overwritten by the core result
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_engine (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  load_en_i,
  input  logic [1:0]            word_idx_i,
  input  logic [`AES_WB_DW-1:0] din_i,
  input  logic                  clear_i,
  input  logic                  core_start_i,
  input  aes_pkg::aes_block_u   key_i,
  output logic [`AES_WB_DW-1:0] dout_o,
  output logic                  core_done_o
);

  aes_pkg::aes_block_u data_q;
  aes_pkg::aes_block_u core_result;
  logic                core_done;

  aes_core u_core (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (core_start_i),
    .key_i    (key_i),
    .block_i  (data_q),
    .result_o (core_result),
    .done_o   (core_done)
  );

  // Clear wins over a finishing core, which wins over a word load
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      data_q <= '0;
    else if (clear_i)
      data_q <= '0;
    else if (core_done)
      data_q <= core_result;
    else if (load_en_i)
      data_q.words[word_idx_i] <= din_i;
  end

  assign dout_o      = data_q.words[word_idx_i];
  assign core_done_o = core_done;

endmodule

`default_nettype wire

/* hw/aes_ctrl_fsm.sv */
// AES control FSM
// Sequences word loading, the core run and word unloading, and turns
// bus events into counter and engine commands
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic din_we_i,
  input  logic dout_re_i,
  input  logic clear_i,
  input  logic word_last_i,
  input  logic core_done_i,
  output logic word_en_o,
  output logic word_clr_o,
  output logic load_en_o,
  output logic core_start_o,
  output logic eng_clear_o,
  output logic busy_o,
  output logic ready_o
);

  localparam logic [2:0] IDLE   = 3'd0;
  localparam logic [2:0] LOAD   = 3'd1;
  localparam logic [2:0] START  = 3'd2;
  localparam logic [2:0] RUN    = 3'd3;
  localparam logic [2:0] UNLOAD = 3'd4;

  logic [2:0] state_q, state_d;
  logic       accept_din;
  logic       accept_dout;

  // Only writes in IDLE or LOAD and reads in UNLOAD reach the data path
  assign accept_din  = din_we_i & ((state_q == IDLE) | (state_q == LOAD)) & ~clear_i;
  assign accept_dout = dout_re_i & (state_q == UNLOAD) & ~clear_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE, LOAD:
      begin
        if (accept_din)
          state_d = word_last_i ? START : LOAD;
      end
      START:
        state_d = RUN;
      RUN:
      begin
        if (core_done_i)
          state_d = UNLOAD;
      end
      UNLOAD:
      begin
        if (accept_dout & word_last_i)
          state_d = IDLE;
      end
      default:
        state_d = IDLE;
    endcase
    if (clear_i)
      state_d = IDLE;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Counter wraps to zero after the fourth word, so no clear between phases
  assign word_en_o    = accept_din | accept_dout;
  assign word_clr_o   = clear_i;
  assign load_en_o    = accept_din;
  assign core_start_o = (state_q == START);
  assign eng_clear_o  = clear_i;
  assign busy_o       = (state_q == START) | (state_q == RUN);
  assign ready_o      = (state_q == UNLOAD);

endmodule

`default_nettype wire

/* hw/aes_wb_regs.sv */
// AES Wishbone register block
// Classic slave with registered ack, key registers, status read-back
// and single-cycle command pulses for the controller
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_wb_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`AES_WB_AW-1:0] wb_adr_i,
  input  logic [`AES_WB_DW-1:0] wb_dat_i,
  input  logic [3:0]            wb_sel_i,
  output logic [`AES_WB_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  din_we_o,
  output logic                  dout_re_o,
  output logic                  clear_o,
  output logic [`AES_WB_DW-1:0] din_o,
  output aes_pkg::aes_block_u   key_o,
  input  logic                  busy_i,
  input  logic                  ready_i,
  input  logic [1:0]            word_idx_i,
  input  logic [`AES_WB_DW-1:0] dout_i
);

  aes_pkg::aes_block_u   key_q;
  logic [`AES_WB_DW-1:0] rdata_q, rdata_d;
  logic [`AES_WB_DW-1:0] din_q;
  logic                  ack_q;
  logic                  din_we_q, dout_re_q, clear_q;
  logic                  access, wr_access, rd_access;

  // Byte strobes are ignored and every write moves a full word
  assign access    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_access = access & wb_we_i;
  assign rd_access = access & ~wb_we_i;

  always_comb
  begin
    case (wb_adr_i)
      `AES_REG_STATUS: rdata_d = {{(`AES_WB_DW-4){1'b0}}, word_idx_i, ready_i, busy_i};
      `AES_REG_KEY0:   rdata_d = key_q.words[0];
      `AES_REG_KEY1:   rdata_d = key_q.words[1];
      `AES_REG_KEY2:   rdata_d = key_q.words[2];
      `AES_REG_KEY3:   rdata_d = key_q.words[3];
      `AES_REG_DOUT:   rdata_d = dout_i;
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_q     <= 1'b0;
      din_we_q  <= 1'b0;
      dout_re_q <= 1'b0;
      clear_q   <= 1'b0;
      rdata_q   <= '0;
      key_q     <= '0;
    end
    else
    begin
      ack_q     <= access;
      din_we_q  <= wr_access & (wb_adr_i == `AES_REG_DIN);
      dout_re_q <= rd_access & (wb_adr_i == `AES_REG_DOUT);
      // Bit 1 of CTRL is the clear command
      clear_q   <= wr_access & (wb_adr_i == `AES_REG_CTRL) & wb_dat_i[1];
      if (rd_access)
        rdata_q <= rdata_d;
      if (wr_access && wb_adr_i[`AES_WB_AW-1:4] == `AES_REG_KEY0 >> 4)
        key_q.words[wb_adr_i[3:2]] <= wb_dat_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_access && wb_adr_i == `AES_REG_DIN)
      din_q <= wb_dat_i;
  end

  assign wb_ack_o  = ack_q;
  assign wb_dat_o  = rdata_q;
  assign din_we_o  = din_we_q;
  assign dout_re_o = dout_re_q;
  assign clear_o   = clear_q;
  assign din_o     = din_q;
  assign key_o     = key_q;

endmodule

`default_nettype wire

/* hw/aes_top.sv */
// AES-128 accelerator top level
// Wishbone register block, control FSM, word counter and engine
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`AES_WB_AW-1:0] wb_adr_i,
  input  logic [`AES_WB_DW-1:0] wb_dat_i,
  input  logic [3:0]            wb_sel_i,
  output logic [`AES_WB_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o
);

  logic                  din_we, dout_re, clear;
  logic [`AES_WB_DW-1:0] din, dout;
  aes_pkg::aes_block_u   key;
  logic                  busy, ready;
  logic [1:0]            word_idx;
  logic                  word_last, word_en, word_clr;
  logic                  load_en, core_start, eng_clear, core_done;

  aes_wb_regs u_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .din_we_o   (din_we),
    .dout_re_o  (dout_re),
    .clear_o    (clear),
    .din_o      (din),
    .key_o      (key),
    .busy_i     (busy),
    .ready_i    (ready),
    .word_idx_i (word_idx),
    .dout_i     (dout)
  );

  aes_ctrl_fsm u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .din_we_i     (din_we),
    .dout_re_i    (dout_re),
    .clear_i      (clear),
    .word_last_i  (word_last),
    .core_done_i  (core_done),
    .word_en_o    (word_en),
    .word_clr_o   (word_clr),
    .load_en_o    (load_en),
    .core_start_o (core_start),
    .eng_clear_o  (eng_clear),
    .busy_o       (busy),
    .ready_o      (ready)
  );

  // Word position within the block, 0 to 3
  aes_step_counter #(.WIDTH(2)) u_word_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clr_i      (word_clr),
    .en_i       (word_en),
    .last_val_i (2'd3),
    .count_o    (word_idx),
    .last_o     (word_last)
  );

  aes_engine u_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_en_i    (load_en),
    .word_idx_i   (word_idx),
    .din_i        (din),
    .clear_i      (eng_clear),
    .core_start_i (core_start),
    .key_i        (key),
    .dout_o       (dout),
    .core_done_o  (core_done)
  );

endmodule

`default_nettype wire

/* tb/aes_tb.sv */
// AES accelerator testbench
// Directed tests over the Wishbone port using the FIPS-197 vectors
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aes_tb;

  localparam int ACK_TIMEOUT = 20;
  localparam int STATUS_POLLS = 100;

  localparam logic [127:0] C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] C1_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [127:0] B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;

  logic                  clk;
  logic                  rst_ni;
  logic                  wb_cyc, wb_stb, wb_we;
  logic [`AES_WB_AW-1:0] wb_adr;
  logic [`AES_WB_DW-1:0] wb_dat_w, wb_dat_r;
  logic [3:0]            wb_sel;
  logic                  wb_ack;
  int                    err_count;
  int                    tests_ok;
  int                    tests_bad;

  aes_top dut_i (
    .clk_i    (clk),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  always #2 clk = ~clk;

  // One bus cycle, driven on the falling edge, ack sampled on the falling edge
  task automatic bus_access(input logic we, input logic [7:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    cycles   = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!wb_ack && cycles < ACK_TIMEOUT);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!wb_ack)
    begin
      $display("Bus access to address %02h got no acknowledge within %0d cycles",
               adr, ACK_TIMEOUT);
      err_count++;
    end
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic read_and_check(input logic [7:0] adr, input string what,
                                input logic [31:0] exp);
    logic [31:0] data;
    wb_read(adr, data);
    check_value(what, data, exp);
  endtask

  // Polls STATUS until the given bit is set, noting whether busy was seen
  task automatic wait_status_bit(input int bit_idx, output bit saw_busy);
    logic [31:0] status;
    int          polls;
    bit          found;
    saw_busy = 1'b0;
    found    = 1'b0;
    polls    = 0;
    while (!found && polls < STATUS_POLLS)
    begin
      wb_read(`AES_REG_STATUS, status);
      polls++;
      if (status[0])
        saw_busy = 1'b1;
      if (status[bit_idx])
        found = 1'b1;
    end
    if (!found)
    begin
      $display("STATUS bit %0d never came up within %0d polls", bit_idx, STATUS_POLLS);
      err_count++;
    end
  endtask

  // Word 0 of a block is its last eight hex digits
  task automatic set_key(input logic [127:0] key);
    for (int i = 0; i < `AES_WORDS; i++)
      wb_write(`AES_REG_KEY0 + 8'(4*i), key[32*i +: 32]);
  endtask

  task automatic load_block(input logic [127:0] pt);
    for (int i = 0; i < `AES_WORDS; i++)
      wb_write(`AES_REG_DIN, pt[32*i +: 32]);
  endtask

  task automatic unload_and_check(input logic [127:0] ct);
    for (int i = 0; i < `AES_WORDS; i++)
      read_and_check(`AES_REG_DOUT, $sformatf("DATA_OUT word %0d", i), ct[32*i +: 32]);
    read_and_check(`AES_REG_STATUS, "STATUS after unload", 32'h0);
  endtask

  task automatic encrypt_and_check(input logic [127:0] pt, input logic [127:0] ct);
    bit saw_busy;
    load_block(pt);
    wait_status_bit(1, saw_busy);
    assert (saw_busy)
    else
    begin
      $display("Error at %0t ns: STATUS never showed busy during the run", $time);
      err_count++;
    end
    read_and_check(`AES_REG_STATUS, "STATUS with result ready", 32'h2);
    unload_and_check(ct);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic test_reset_state();
    int errs_before;
    errs_before = err_count;
    read_and_check(`AES_REG_STATUS, "STATUS after reset", 32'h0);
    read_and_check(`AES_REG_DOUT, "DATA_OUT after reset", 32'h0);
    for (int i = 0; i < `AES_WORDS; i++)
      read_and_check(`AES_REG_KEY0 + 8'(4*i), $sformatf("KEY%0d after reset", i), 32'h0);
    finish_test("reset_state", errs_before);
  endtask

  task automatic test_key_readback();
    int errs_before;
    errs_before = err_count;
    for (int i = 0; i < `AES_WORDS; i++)
      wb_write(`AES_REG_KEY0 + 8'(4*i), 32'ha5c3_0f00 ^ (32'h1111_1111 * (i + 1)));
    for (int i = 0; i < `AES_WORDS; i++)
      read_and_check(`AES_REG_KEY0 + 8'(4*i), $sformatf("KEY%0d", i),
                     32'ha5c3_0f00 ^ (32'h1111_1111 * (i + 1)));
    finish_test("key_readback", errs_before);
  endtask

  task automatic test_fips_c1();
    int errs_before;
    errs_before = err_count;
    set_key(C1_KEY);
    encrypt_and_check(C1_PT, C1_CT);
    finish_test("fips_c1", errs_before);
  endtask

  task automatic test_fips_b();
    int errs_before;
    errs_before = err_count;
    set_key(B_KEY);
    encrypt_and_check(B_PT, B_CT);
    finish_test("fips_appendix_b", errs_before);
  endtask

  task automatic test_clear_mid_load();
    int errs_before;
    errs_before = err_count;
    set_key(C1_KEY);
    wb_write(`AES_REG_DIN, 32'h1234_5678);
    wb_write(`AES_REG_DIN, 32'h9abc_def0);
    wb_write(`AES_REG_CTRL, 32'h2);
    read_and_check(`AES_REG_STATUS, "STATUS after clear", 32'h0);
    encrypt_and_check(C1_PT, C1_CT);
    finish_test("clear_mid_load", errs_before);
  endtask

  task automatic test_ignored_writes();
    int errs_before;
    bit saw_busy;
    errs_before = err_count;
    set_key(C1_KEY);
    load_block(C1_PT);
    wait_status_bit(0, saw_busy);
    // Stray words while the core runs
    wb_write(`AES_REG_DIN, 32'hdead_beef);
    wb_write(`AES_REG_DIN, 32'h0bad_f00d);
    wait_status_bit(1, saw_busy);
    wb_write(`AES_REG_DIN, 32'hfeed_face);
    read_and_check(`AES_REG_STATUS, "STATUS after stray write", 32'h2);
    unload_and_check(C1_CT);
    finish_test("ignored_writes", errs_before);
  endtask

  initial
  begin
    clk       = 1'b0;
    rst_ni    = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    wb_sel    = 4'hf;
    err_count = 0;
    tests_ok  = 0;
    tests_bad = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;

    test_reset_state();
    test_key_readback();
    test_fips_c1();
    test_fips_b();
    test_clear_mid_load();
    test_ignored_writes();

    $display("tests ok: %0d, tests with errors: %0d, errors: %0d",
             tests_ok, tests_bad, err_count);
    if (err_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/aes_pkg.sv
hw/aes_round.sv
hw/aes_step_counter.sv
hw/aes_core.sv
hw/aes_engine.sv
hw/aes_ctrl_fsm.sv
hw/aes_wb_regs.sv
hw/aes_top.sv
tb/aes_tb.sv

/* Bender.yml */
package:
  name: aes_wb_accel

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/aes_pkg.sv
      - hw/aes_round.sv
      - hw/aes_step_counter.sv
      - hw/aes_core.sv
      - hw/aes_engine.sv
      - hw/aes_ctrl_fsm.sv
      - hw/aes_wb_regs.sv
      - hw/aes_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/aes_tb.sv
